//--- Makefile
SRCS = carbon_sys_pkg.sv boot_rom_image.svh sys_fabric.sv tier_host_ctrl.sv mmio_regs.sv \
       boot_rom.sv sys_sram.sv carbon_sys_top.sv tb_carbon_sys.sv

obj_dir/Vtb_carbon_sys: compile.f $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_carbon_sys -f compile.f

run: obj_dir/Vtb_carbon_sys
	@out="$$(./obj_dir/Vtb_carbon_sys)"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- boot_rom.sv
/* Boot ROM target, contents fixed by the included image table.
   Reads take word index bits 7:2; writes leave the contents and answer with err. */
`timescale 1ns/1ps

module boot_rom (
  input  logic                     clk,
  input  logic                     rst_n,
  input  carbon_sys_pkg::bus_req_t bus_req,
  output carbon_sys_pkg::bus_rsp_t bus_rsp
);

  `include "boot_rom_image.svh"

  logic [5:0] word_idx;

  assign word_idx = bus_req.addr[7:2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_rsp <= '0;
    end else begin
      bus_rsp.valid <= bus_req.valid;
      bus_rsp.err   <= bus_req.valid && bus_req.write;
      bus_rsp.rdata <= bus_req.write ? '0 : rom_image[word_idx];
    end
  end

endmodule

//--- boot_rom_image.svh
/* Boot ROM contents as a table of 32-bit words.
   Include inside a module body; both the ROM and the testbench read rom_image. */

// Boot stub occupies the first six words
// Everything past the stub reads as zero
localparam carbon_sys_pkg::word_t rom_image [carbon_sys_pkg::rom_words] = '{
  // Entry jump into the stub
  0: 32'hC001_0F00,
  // Point at the MMIO window
  1: 32'h2000_F000,
  // Signature value to publish
  2: 32'h5A34_0220,
  3: 32'h0000_22A4,
  // Poll loop back to word 2
  4: 32'h3830_0220,
  // Halt
  5: 32'h7600_0000,
  default: '0
};

//--- carbon_sys_pkg.sv
/* Widths, address map, credit count and bus types shared by the Carbon bring-up system.
   Modules and the testbench refer to these by scoped name. */
package carbon_sys_pkg;

  // --------------------
  // Bus widths
  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 32;

  typedef logic [data_w-1:0] word_t;

  // Credits held by the master after reset, also the fabric queue depth
  localparam int unsigned req_credits = 2;
  localparam int unsigned q_ptr_w = (req_credits > 1) ? $clog2(req_credits) : 1;
  localparam int unsigned q_cnt_w = $clog2(req_credits + 1);

  // --------------------
  // Address map, 16-bit compatible decode on bits 15:8
  localparam logic [addr_w-1:0] sys16_mask     = 32'h0000_FF00;
  localparam logic [addr_w-1:0] mmio_base      = 32'h0000_F000;
  localparam logic [addr_w-1:0] tier_host_base = 32'h0000_F100;
  localparam logic [addr_w-1:0] rom_base       = 32'h0000_E000;

  // MMIO register offsets
  localparam logic [7:0] mmio_sig_off      = 8'h00;
  localparam logic [7:0] mmio_poweroff_off = 8'h04;

  // Tier host register offsets
  localparam logic [7:0] tier_active_off = 8'h00;
  localparam logic [7:0] tier_halt_off   = 8'h04;
  localparam logic [7:0] tier_run_off    = 8'h08;

  // Memory sizes in words
  localparam int unsigned rom_words = 64;
  localparam int unsigned ram_words = 1024;

  // Hosted cores behind the tier controller
  localparam int unsigned core_count = 4;

  // --------------------
  // Bus types
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [addr_w-1:0] addr;
    word_t             wdata;
  } bus_req_t;

  typedef struct packed {
    logic  valid;
    logic  err;
    word_t rdata;
  } bus_rsp_t;

  // RAM is the default when no base matches
  typedef enum logic [1:0] {
    target_mmio,
    target_tier_host,
    target_rom,
    target_ram
  } target_e;

endpackage

//--- carbon_sys_top.sv
/* Carbon bring-up system top: the request fabric and its four targets.
   A single credit-counting master drives req and accepts every rsp. */
`timescale 1ns/1ps

module carbon_sys_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  carbon_sys_pkg::bus_req_t              req,
  output logic                                  credit,
  output carbon_sys_pkg::bus_rsp_t              rsp,
  output carbon_sys_pkg::word_t                 signature,
  output logic                                  poweroff,
  output logic [7:0]                            active_tier,
  output logic [1:0]                            active_core,
  output logic [carbon_sys_pkg::core_count-1:0] halt_req,
  output logic [carbon_sys_pkg::core_count-1:0] run_pulse
);

  carbon_sys_pkg::bus_req_t mmio_req;
  carbon_sys_pkg::bus_req_t tier_req;
  carbon_sys_pkg::bus_req_t rom_req;
  carbon_sys_pkg::bus_req_t ram_req;
  carbon_sys_pkg::bus_rsp_t mmio_rsp;
  carbon_sys_pkg::bus_rsp_t tier_rsp;
  carbon_sys_pkg::bus_rsp_t rom_rsp;
  carbon_sys_pkg::bus_rsp_t ram_rsp;

  // --------------------
  // Fabric
  sys_fabric u_fabric (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .credit   (credit),
    .rsp      (rsp),
    .mmio_req (mmio_req),
    .tier_req (tier_req),
    .rom_req  (rom_req),
    .ram_req  (ram_req),
    .mmio_rsp (mmio_rsp),
    .tier_rsp (tier_rsp),
    .rom_rsp  (rom_rsp),
    .ram_rsp  (ram_rsp)
  );

  // --------------------
  // Targets
  mmio_regs u_mmio (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_req   (mmio_req),
    .bus_rsp   (mmio_rsp),
    .signature (signature),
    .poweroff  (poweroff)
  );

  tier_host_ctrl u_tier_host (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus_req     (tier_req),
    .bus_rsp     (tier_rsp),
    .active_tier (active_tier),
    .active_core (active_core),
    .halt_req    (halt_req),
    .run_pulse   (run_pulse)
  );

  boot_rom u_rom (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (rom_req),
    .bus_rsp (rom_rsp)
  );

  sys_sram u_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (ram_req),
    .bus_rsp (ram_rsp)
  );

endmodule

//--- compile.f
+incdir+.
carbon_sys_pkg.sv
sys_fabric.sv
tier_host_ctrl.sv
mmio_regs.sv
boot_rom.sv
sys_sram.sv
carbon_sys_top.sv
tb_carbon_sys.sv

//--- mmio_regs.sv
/* System MMIO block: a read/write signature word and a sticky power-off bit.
   Undefined offsets read as zero. */
`timescale 1ns/1ps

module mmio_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  carbon_sys_pkg::bus_req_t bus_req,
  output carbon_sys_pkg::bus_rsp_t bus_rsp,
  output carbon_sys_pkg::word_t    signature,
  output logic                     poweroff
);

  logic                  wr_en;
  carbon_sys_pkg::word_t rd_data;

  assign wr_en = bus_req.valid && bus_req.write;

  always_comb begin
    case (bus_req.addr[7:0])
      carbon_sys_pkg::mmio_sig_off:      rd_data = signature;
      carbon_sys_pkg::mmio_poweroff_off: rd_data = carbon_sys_pkg::word_t'(poweroff);
      default:                           rd_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      signature <= '0;
      poweroff  <= 1'b0;
      bus_rsp   <= '0;
    end else begin
      bus_rsp <= '{valid: bus_req.valid, err: 1'b0, rdata: bus_req.write ? '0 : rd_data};
      if (wr_en && bus_req.addr[7:0] == carbon_sys_pkg::mmio_sig_off) begin
        signature <= bus_req.wdata;
      end
      // Only a 1 is taken, the bit holds until reset
      if (wr_en && bus_req.addr[7:0] == carbon_sys_pkg::mmio_poweroff_off &&
          bus_req.wdata[0]) begin
        poweroff <= 1'b1;
      end
    end
  end

endmodule

//--- sys_fabric.sv
/* Request fabric: queues master requests, returns credits, decodes each address
   and routes it to one target, then selects the matching response in order. */
`timescale 1ns/1ps

module sys_fabric (
  input  logic                     clk,
  input  logic                     rst_n,
  input  carbon_sys_pkg::bus_req_t req,
  output logic                     credit,
  output carbon_sys_pkg::bus_rsp_t rsp,
  output carbon_sys_pkg::bus_req_t mmio_req,
  output carbon_sys_pkg::bus_req_t tier_req,
  output carbon_sys_pkg::bus_req_t rom_req,
  output carbon_sys_pkg::bus_req_t ram_req,
  input  carbon_sys_pkg::bus_rsp_t mmio_rsp,
  input  carbon_sys_pkg::bus_rsp_t tier_rsp,
  input  carbon_sys_pkg::bus_rsp_t rom_rsp,
  input  carbon_sys_pkg::bus_rsp_t ram_rsp
);

  typedef logic [carbon_sys_pkg::q_ptr_w-1:0] ptr_t;
  typedef logic [carbon_sys_pkg::q_cnt_w-1:0] cnt_t;

  carbon_sys_pkg::bus_req_t q_mem [carbon_sys_pkg::req_credits];
  ptr_t                     wr_ptr;
  ptr_t                     rd_ptr;
  cnt_t                     count;
  logic                     pop;
  carbon_sys_pkg::bus_req_t head;
  carbon_sys_pkg::target_e  head_tgt;
  carbon_sys_pkg::bus_req_t issue_req;
  carbon_sys_pkg::target_e  issue_tgt;
  carbon_sys_pkg::target_e  rsp_tgt;

  function automatic ptr_t next_ptr(input ptr_t p);
    return (p == ptr_t'(carbon_sys_pkg::req_credits - 1)) ? '0 : p + 1'b1;
  endfunction

  function automatic logic base_hit(input logic [carbon_sys_pkg::addr_w-1:0] addr,
                                    input logic [carbon_sys_pkg::addr_w-1:0] base);
    return (addr & carbon_sys_pkg::sys16_mask) == (base & carbon_sys_pkg::sys16_mask);
  endfunction

  function automatic carbon_sys_pkg::bus_req_t route(input carbon_sys_pkg::bus_req_t r,
                                                     input logic sel);
    carbon_sys_pkg::bus_req_t o;
    o = r;
    o.valid = r.valid && sel;
    return o;
  endfunction

  // --------------------
  // Request queue
  // The master never holds more credits than free entries, so no full check
  always_ff @(posedge clk) begin
    if (req.valid) begin
      q_mem[wr_ptr] <= req;
    end
  end

  assign pop  = (count != '0);
  assign head = q_mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (req.valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + cnt_t'(req.valid) - cnt_t'(pop);
    end
  end

  // --------------------
  // Decode of the head entry, upper 16 address bits ignored
  always_comb begin
    if (base_hit(head.addr, carbon_sys_pkg::mmio_base)) begin
      head_tgt = carbon_sys_pkg::target_mmio;
    end else if (base_hit(head.addr, carbon_sys_pkg::tier_host_base)) begin
      head_tgt = carbon_sys_pkg::target_tier_host;
    end else if (base_hit(head.addr, carbon_sys_pkg::rom_base)) begin
      head_tgt = carbon_sys_pkg::target_rom;
    end else begin
      head_tgt = carbon_sys_pkg::target_ram;
    end
  end

  // Issue stage, one entry per cycle; credit returns as the entry leaves
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_req <= '0;
      issue_tgt <= carbon_sys_pkg::target_ram;
      rsp_tgt   <= carbon_sys_pkg::target_ram;
      credit    <= 1'b0;
    end else begin
      issue_req <= '{valid: pop, write: head.write, addr: head.addr, wdata: head.wdata};
      issue_tgt <= head_tgt;
      rsp_tgt   <= issue_tgt;
      credit    <= pop;
    end
  end

  assign mmio_req = route(issue_req, issue_tgt == carbon_sys_pkg::target_mmio);
  assign tier_req = route(issue_req, issue_tgt == carbon_sys_pkg::target_tier_host);
  assign rom_req  = route(issue_req, issue_tgt == carbon_sys_pkg::target_rom);
  assign ram_req  = route(issue_req, issue_tgt == carbon_sys_pkg::target_ram);

  // Targets answer one cycle after issue, rsp_tgt lines up with that cycle
  always_comb begin
    case (rsp_tgt)
      carbon_sys_pkg::target_mmio:      rsp = mmio_rsp;
      carbon_sys_pkg::target_tier_host: rsp = tier_rsp;
      carbon_sys_pkg::target_rom:       rsp = rom_rsp;
      default:                          rsp = ram_rsp;
    endcase
  end

endmodule

//--- sys_sram.sv
/* Word-wide system RAM, the default target for every unclaimed address.
   Index comes from address bits 11:2; contents are not reset. */
`timescale 1ns/1ps

module sys_sram (
  input  logic                     clk,
  input  logic                     rst_n,
  input  carbon_sys_pkg::bus_req_t bus_req,
  output carbon_sys_pkg::bus_rsp_t bus_rsp
);

  carbon_sys_pkg::word_t mem [carbon_sys_pkg::ram_words];
  logic [9:0]            word_idx;
  carbon_sys_pkg::word_t rdata_q;
  logic                  rsp_valid;

  assign word_idx = bus_req.addr[11:2];

  // Storage and read data
  always_ff @(posedge clk) begin
    if (bus_req.valid && bus_req.write) begin
      mem[word_idx] <= bus_req.wdata;
    end
    rdata_q <= bus_req.write ? '0 : mem[word_idx];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= bus_req.valid;
    end
  end

  assign bus_rsp = '{valid: rsp_valid, err: 1'b0, rdata: rdata_q};

endmodule

//--- tb_carbon_sys.sv
/* Testbench for the Carbon bring-up system with a credit-aware bus driver, a reference
   model and assertion checks over RAM, MMIO, boot ROM and tier host. */
`timescale 1ns/1ps

module tb_carbon_sys;

  `include "boot_rom_image.svh"

  // One expected response queued in request order
  typedef struct packed {
    logic        chk_data;
    logic        err;
    logic [31:0] rdata;
    logic        empty;
    logic [31:0] sent_at;
  } exp_t;

  logic                                  clk;
  logic                                  rst_n;
  carbon_sys_pkg::bus_req_t              req;
  logic                                  credit;
  carbon_sys_pkg::bus_rsp_t              rsp;
  carbon_sys_pkg::word_t                 signature;
  logic                                  poweroff;
  logic [7:0]                            active_tier;
  logic [1:0]                            active_core;
  logic [carbon_sys_pkg::core_count-1:0] halt_req;
  logic [carbon_sys_pkg::core_count-1:0] run_pulse;

  int                                    credits;
  int                                    cycle;
  int                                    sent;
  int                                    rsp_seen;
  int                                    checks;
  int                                    errors;
  int                                    tests;
  int                                    pulse_count;
  logic [carbon_sys_pkg::core_count-1:0] last_pulse;
  logic [2:0]                            acc_hist;
  logic                                  timed_out;
  logic [31:0]                           rng_state;
  exp_t                                  exp_q [$];

  // Reference model state
  logic [31:0]                           model_ram [carbon_sys_pkg::ram_words];
  logic [31:0]                           model_sig;
  logic                                  model_poff;
  logic [7:0]                            model_tier;
  logic [1:0]                            model_core;
  logic [carbon_sys_pkg::core_count-1:0] model_halt;

  carbon_sys_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .credit      (credit),
    .rsp         (rsp),
    .signature   (signature),
    .poweroff    (poweroff),
    .active_tier (active_tier),
    .active_core (active_core),
    .halt_req    (halt_req),
    .run_pulse   (run_pulse)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // Credit count and accept history
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits  <= int'(carbon_sys_pkg::req_credits);
      acc_hist <= '0;
    end else begin
      credits  <= credits + int'(credit) - int'(req.valid);
      acc_hist <= {acc_hist[1:0], req.valid};
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // A request accepted at t sees its credit at t+2 and its response at t+3
  assert property (@(posedge clk) disable iff (!rst_n) credit == acc_hist[1])
    else begin
      errors++;
      $display("[FAIL] %0t credit expected %0b got %0b", $time,
               $sampled(acc_hist[1]), $sampled(credit));
    end

  assert property (@(posedge clk) disable iff (!rst_n) rsp.valid == acc_hist[2])
    else begin
      errors++;
      $display("[FAIL] %0t rsp.valid expected %0b got %0b", $time,
               $sampled(acc_hist[2]), $sampled(rsp.valid));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
                   credits >= 0 && credits <= int'(carbon_sys_pkg::req_credits))
    else begin
      errors++;
      $display("%0t: outstanding requests went outside the credit range", $time);
    end

  assert property (@(posedge clk) disable iff (!rst_n) run_pulse != '0 |=> run_pulse == '0)
    else begin
      errors++;
      $display("%0t: run_pulse stayed high for two cycles", $time);
    end

  function automatic void check_value(input string name, input logic [31:0] got,
                                      input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
      end
  endfunction

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // --------------------
  // Reference model decoding on address bits 15:8
  function automatic exp_t model_access(input logic wr, input logic [31:0] addr,
                                        input logic [31:0] data);
    exp_t e;
    e = '0;
    e.chk_data = !wr;
    case (addr[15:8])
      carbon_sys_pkg::mmio_base[15:8]: begin
        if (addr[7:0] == carbon_sys_pkg::mmio_sig_off) begin
          e.rdata = model_sig;
          if (wr) model_sig = data;
        end else if (addr[7:0] == carbon_sys_pkg::mmio_poweroff_off) begin
          e.rdata = 32'(model_poff);
          if (wr && data[0]) model_poff = 1'b1;
        end
      end
      carbon_sys_pkg::tier_host_base[15:8]: begin
        if (addr[7:0] == carbon_sys_pkg::tier_active_off) begin
          e.rdata = {22'b0, model_core, model_tier};
          if (wr) {model_core, model_tier} = data[9:0];
        end else if (addr[7:0] == carbon_sys_pkg::tier_halt_off) begin
          e.rdata = 32'(model_halt);
          if (wr) model_halt = data[carbon_sys_pkg::core_count-1:0];
        end else if (addr[7:0] == carbon_sys_pkg::tier_run_off && wr) begin
          model_halt &= ~data[carbon_sys_pkg::core_count-1:0];
        end
      end
      carbon_sys_pkg::rom_base[15:8]: begin
        e.rdata = rom_image[addr[7:2]];
        e.err   = wr;
      end
      default: begin
        e.rdata = model_ram[addr[11:2]];
        if (wr) model_ram[addr[11:2]] = data;
      end
    endcase
    return e;
  endfunction

  // --------------------
  // Response and run pulse monitors
  always @(posedge clk) begin
    exp_t e;
    if (rst_n && rsp.valid) begin
      rsp_seen <= rsp_seen + 1;
      if (exp_q.size() == 0) begin
        errors++;
        $display("%0t: response arrived with no request outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        check_value("rsp.err", 32'(rsp.err), 32'(e.err));
        if (e.chk_data) check_value("rsp.rdata", rsp.rdata, e.rdata);
        if (e.empty) check_value("rsp latency", 32'(cycle) - e.sent_at, 32'd4);
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && run_pulse != '0) begin
      pulse_count <= pulse_count + 1;
      last_pulse  <= run_pulse;
    end
  end

  // --------------------
  // Bus driver
  task automatic send(input logic wr, input logic [31:0] addr, input logic [31:0] data);
    int   waited;
    exp_t e;
    waited = 0;
    @(posedge clk);
    // A request driven last edge is not yet taken off the count
    while (credits - int'(req.valid) <= 0 && !timed_out) begin
      req.valid <= 1'b0;
      waited++;
      if (waited > 50) begin
        timed_out = 1'b1;
        $display("%0t: timeout, no credit came back to the master", $time);
      end
      @(posedge clk);
    end
    if (timed_out) return;
    e         = model_access(wr, addr, data);
    e.empty   = (credits == int'(carbon_sys_pkg::req_credits)) && !req.valid;
    e.sent_at = 32'(cycle);
    exp_q.push_back(e);
    sent <= sent + 1;
    req  <= '{valid: 1'b1, write: wr, addr: addr, wdata: data};
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(posedge clk);
    req.valid <= 1'b0;
    while ((rsp_seen != sent || credits != int'(carbon_sys_pkg::req_credits)) && !timed_out) begin
      waited++;
      if (waited > 100) begin
        timed_out = 1'b1;
        $display("%0t: timeout, responses or credits did not come back", $time);
      end
      @(posedge clk);
    end
  endtask

  task automatic end_test(input string name, input int checks0, input int errors0);
    tests++;
    $display("test %-8s %0d checks, %0d errors", name, checks - checks0, errors - errors0);
  endtask

  // --------------------
  // Test sequence
  initial begin
    int          c0;
    int          e0;
    int          p0;
    logic [31:0] addrs [16];
    logic [31:0] hi;
    rst_n = 1'b0;
    req = '0;
    cycle = 0;
    sent = 0;
    rsp_seen = 0;
    checks = 0;
    errors = 0;
    tests = 0;
    pulse_count = 0;
    last_pulse = '0;
    timed_out = 1'b0;
    rng_state = 32'd91353;
    model_sig = '0;
    model_poff = 1'b0;
    model_tier = '0;
    model_core = '0;
    model_halt = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    c0 = checks;
    e0 = errors;
    @(posedge clk);
    check_value("credit", 32'(credit), 32'd0);
    check_value("rsp.valid", 32'(rsp.valid), 32'd0);
    check_value("poweroff", 32'(poweroff), 32'd0);
    check_value("halt_req", 32'(halt_req), 32'd0);
    check_value("run_pulse", 32'(run_pulse), 32'd0);
    check_value("signature", signature, 32'd0);
    check_value("active_tier", 32'(active_tier), 32'd0);
    check_value("active_core", 32'(active_core), 32'd0);
    end_test("reset", c0, e0);

    // Lone requests on an empty queue and then a burst holding both credits
    c0 = checks;
    e0 = errors;
    send(1'b1, 32'h0000_0100, 32'h1234_5678);
    drain();
    send(1'b0, 32'h0000_0100, 32'h0);
    drain();
    for (int i = 0; i < 8; i++) begin
      send(i < 4, 32'h0000_0200 + 32'(4 * (i % 4)), next_random());
    end
    drain();
    end_test("credit", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      addrs[i] = next_random() & 32'hFFFF_0FFC;
      send(1'b1, addrs[i], next_random());
    end
    for (int i = 0; i < 16; i++) begin
      send(1'b0, addrs[i], 32'h0);
    end
    drain();
    end_test("ram", c0, e0);

    // Upper address bits are random and must not change the decode
    c0 = checks;
    e0 = errors;
    hi = next_random();
    send(1'b1, {hi[31:16], 16'hF000}, next_random());
    hi = next_random();
    send(1'b0, {hi[31:16], 16'hF000}, 32'h0);
    send(1'b0, {hi[31:16], 16'hF00C}, 32'h0);
    send(1'b1, {hi[31:16], 16'hF004}, 32'h1);
    send(1'b0, {hi[31:16], 16'hF004}, 32'h0);
    drain();
    check_value("signature", signature, model_sig);
    check_value("poweroff", 32'(poweroff), 32'd1);
    send(1'b1, 32'h0000_F004, 32'h0);
    send(1'b0, 32'h0000_F004, 32'h0);
    drain();
    check_value("poweroff", 32'(poweroff), 32'd1);
    end_test("mmio", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      hi = next_random();
      send(1'b0, {hi[31:16], 16'hE000} + 32'(4 * i), 32'h0);
    end
    send(1'b1, 32'h0000_E008, next_random());
    send(1'b0, 32'h0000_E008, 32'h0);
    drain();
    end_test("rom", c0, e0);

    c0 = checks;
    e0 = errors;
    send(1'b1, 32'h0000_F100, next_random());
    send(1'b0, 32'h0000_F100, 32'h0);
    send(1'b1, 32'h0000_F104, 32'hF);
    send(1'b0, 32'h0000_F104, 32'h0);
    drain();
    check_value("active_tier", 32'(active_tier), 32'(model_tier));
    check_value("active_core", 32'(active_core), 32'(model_core));
    check_value("halt_req", 32'(halt_req), 32'(model_halt));
    p0 = pulse_count;
    send(1'b1, 32'h0000_F108, 32'h5);
    send(1'b0, 32'h0000_F108, 32'h0);
    send(1'b0, 32'h0000_F104, 32'h0);
    drain();
    check_value("run_pulse count", 32'(pulse_count - p0), 32'd1);
    check_value("run_pulse", 32'(last_pulse), 32'h5);
    check_value("halt_req", 32'(halt_req), 32'(model_halt));
    end_test("tier", c0, e0);

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- tier_host_ctrl.sv
/* Tier host controller: active tier and core select, per-core halt mask and
   one-cycle run pulses, all written over the system bus. */
`timescale 1ns/1ps

module tier_host_ctrl (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  carbon_sys_pkg::bus_req_t              bus_req,
  output carbon_sys_pkg::bus_rsp_t              bus_rsp,
  output logic [7:0]                            active_tier,
  output logic [1:0]                            active_core,
  output logic [carbon_sys_pkg::core_count-1:0] halt_req,
  output logic [carbon_sys_pkg::core_count-1:0] run_pulse
);

  logic                 wr_en;
  carbon_sys_pkg::word_t rd_data;

  assign wr_en = bus_req.valid && bus_req.write;

  // Run register always reads back zero
  always_comb begin
    case (bus_req.addr[7:0])
      carbon_sys_pkg::tier_active_off: rd_data = carbon_sys_pkg::word_t'({active_core, active_tier});
      carbon_sys_pkg::tier_halt_off:   rd_data = carbon_sys_pkg::word_t'(halt_req);
      default:                         rd_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_tier <= '0;
      active_core <= '0;
      halt_req    <= '0;
      run_pulse   <= '0;
      bus_rsp     <= '0;
    end else begin
      run_pulse <= '0;
      bus_rsp   <= '{valid: bus_req.valid, err: 1'b0, rdata: bus_req.write ? '0 : rd_data};
      if (wr_en) begin
        case (bus_req.addr[7:0])
          carbon_sys_pkg::tier_active_off: begin
            active_tier <= bus_req.wdata[7:0];
            active_core <= bus_req.wdata[9:8];
          end
          carbon_sys_pkg::tier_halt_off: begin
            halt_req <= bus_req.wdata[carbon_sys_pkg::core_count-1:0];
          end
          carbon_sys_pkg::tier_run_off: begin
            // Releasing a core drops its halt request
            run_pulse <= bus_req.wdata[carbon_sys_pkg::core_count-1:0];
            halt_req  <= halt_req & ~bus_req.wdata[carbon_sys_pkg::core_count-1:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule
